//--- bench/memory_model.sv
`default_nettype none

`include "shader_config.svh"

module memory_model (
    input logic clock,
    input logic run,
    input logic [`SHADER_ADDRESS_WIDTH-1:0] inst_ram_address,
    output logic [`SHADER_WORD_WIDTH-1:0] inst_ram_read_result,
    input logic [`SHADER_ADDRESS_WIDTH-1:0] data_ram_address,
    input logic [`SHADER_WORD_WIDTH-1:0] data_ram_write_data,
    input logic data_ram_write,
    output logic [`SHADER_WORD_WIDTH-1:0] data_ram_read_result,
    input logic sdram_write,
    output logic sdram_waitrequest
);

    // the testbench fills these word arrays before reset ends
    logic [`SHADER_WORD_WIDTH-1:0] inst_mem [0:63];
    logic [`SHADER_WORD_WIDTH-1:0] data_mem [0:255];
    logic busy;

    always @(posedge clock) begin
        inst_ram_read_result <= inst_mem[inst_ram_address[7:2]];
        data_ram_read_result <= data_mem[data_ram_address[9:2]];
        if (data_ram_write) begin
            data_mem[data_ram_address[9:2]] <= data_ram_write_data;
        end
        // random hold time on the SDRAM port
        busy <= ($urandom % 3) != 0;
    end

    // a stopped core cannot complete a write, so the port waits too
    assign sdram_waitrequest = sdram_write && (busy || !run);

endmodule

`default_nettype wire

//--- bench/shader_core_tb.sv
`default_nettype none

`include "shader_config.svh"

module shader_core_tb;

    localparam int inst_base = 0;
    localparam int data_base = 64;
    localparam int event_base = 80;
    localparam int idle_window = 200;
    localparam int halt_timeout = 20000;
    localparam logic [31:0] halt_word = {12'(`SHADER_HALT_CODE), 13'h0, 7'b1110011};

    logic clock;
    logic reset_n;
    logic run;
    logic halted;
    logic [`SHADER_ADDRESS_WIDTH-1:0] inst_ram_address;
    logic [`SHADER_WORD_WIDTH-1:0] inst_ram_read_result;
    logic [`SHADER_ADDRESS_WIDTH-1:0] data_ram_address;
    logic [`SHADER_WORD_WIDTH-1:0] data_ram_write_data;
    logic data_ram_write;
    logic [`SHADER_WORD_WIDTH-1:0] data_ram_read_result;
    logic [`SHADER_SDRAM_ADDRESS_WIDTH-1:0] sdram_address;
    logic [`SHADER_WORD_WIDTH-1:0] sdram_writedata;
    logic sdram_write;
    logic sdram_waitrequest;

    logic [31:0] trace [0:127];
    int event_index;
    int checks;
    int errors;
    int halt_address;
    bit halt_seen;

    shader_core dut_i (
        .clock(clock),
        .reset_n(reset_n),
        .run(run),
        .halted(halted),
        .inst_ram_address(inst_ram_address),
        .inst_ram_read_result(inst_ram_read_result),
        .data_ram_address(data_ram_address),
        .data_ram_write_data(data_ram_write_data),
        .data_ram_write(data_ram_write),
        .data_ram_read_result(data_ram_read_result),
        .sdram_address(sdram_address),
        .sdram_writedata(sdram_writedata),
        .sdram_write(sdram_write),
        .sdram_waitrequest(sdram_waitrequest)
    );

    memory_model mem_i (
        .clock(clock),
        .run(run),
        .inst_ram_address(inst_ram_address),
        .inst_ram_read_result(inst_ram_read_result),
        .data_ram_address(data_ram_address),
        .data_ram_write_data(data_ram_write_data),
        .data_ram_write(data_ram_write),
        .data_ram_read_result(data_ram_read_result),
        .sdram_write(sdram_write),
        .sdram_waitrequest(sdram_waitrequest)
    );

    always #4 clock = ~clock;

    // random gaps with run low once reset is over
    always @(posedge clock) begin
        if (reset_n) begin
            run <= ($urandom % 4) != 0;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    // kind 1 is a data RAM write, 2 an SDRAM write, 3 the halt
    task automatic match_event(input int kind, input string addr_name, input logic [31:0] addr,
                               input string data_name, input logic [31:0] data);
        int base;
        int errors_before;
        base = event_base + 3 * event_index;
        errors_before = errors;
        checks++;
        assert (trace[base] == kind) else begin
            errors++;
            $display("event %0d of kind %0d arrived, the trace expects kind %0d there",
                event_index, kind, trace[base]);
        end
        if (trace[base] == kind) begin
            if (kind != 3) begin
                compare_value(addr_name, addr, trace[base + 1]);
                compare_value(data_name, data, trace[base + 2]);
            end
            $display("event %0d kind %0d at %h: %s", event_index, kind, addr,
                (errors == errors_before) ? "ok" : "wrong");
            event_index++;
        end
    endtask

    // outputs are stable at the falling edge, and a write seen here completes at the next rise
    always @(negedge clock) begin
        if (reset_n) begin
            if (data_ram_write) begin
                match_event(1, "data_ram_address", 32'(data_ram_address),
                    "data_ram_write_data", data_ram_write_data);
            end
            if (sdram_write && !sdram_waitrequest) begin
                match_event(2, "sdram_address", 32'(sdram_address),
                    "sdram_writedata", sdram_writedata);
            end
            if (halted && !halt_seen) begin
                halt_seen = 1'b1;
                match_event(3, "", 32'h0, "", 32'h0);
            end
            if (halt_seen) begin
                checks++;
                assert (halted) else begin
                    errors++;
                    $display("halted went low again after the halt");
                end
                // no fetch follows the halt
                compare_value("inst_ram_address", 32'(inst_ram_address), 32'(halt_address));
            end
        end
    end

    initial begin
        int cycles;
        void'($urandom(32'h53bb));
        clock = 1'b0;
        reset_n = 1'b0;
        run = 1'b0;
        event_index = 0;
        checks = 0;
        errors = 0;
        halt_seen = 1'b0;

        for (int i = 0; i < 128; i++) begin
            trace[i] = 32'h0;
        end
        $readmemh("bench/shader_trace.txt", trace);
        for (int i = 0; i < 64; i++) begin
            mem_i.inst_mem[i] = trace[inst_base + i];
        end
        // background pattern first, then the words the program loads
        for (int i = 0; i < 256; i++) begin
            mem_i.data_mem[i] = 32'hd0d00000 | (i << 2);
        end
        for (int i = 0; i < 16; i++) begin
            mem_i.data_mem[i] = trace[data_base + i];
        end

        // the core stops with its fetch address on the first halt word
        halt_address = -1;
        for (int i = 0; i < 64; i++) begin
            if (halt_address < 0 && trace[inst_base + i] == halt_word) begin
                halt_address = i * `SHADER_INST_STEP;
            end
        end

        repeat (10) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);
        compare_value("halted", 32'(halted), 32'h0);
        compare_value("data_ram_write", 32'(data_ram_write), 32'h0);
        compare_value("sdram_write", 32'(sdram_write), 32'h0);
        $display("test reset state: %s", (errors == 0) ? "ok" : "wrong");

        cycles = 0;
        while (!halt_seen && cycles < halt_timeout) begin
            @(posedge clock);
            cycles++;
        end
        if (!halt_seen) begin
            $display("timeout after %0d cycles waiting for the halt", cycles);
            $display("Regression failed");
            $finish;
        end else begin
            $display("test program run: halted after %0d cycles", cycles);

            // any write in this window shows up as an event past the end
            cycles = 0;
            while (cycles < idle_window) begin
                @(posedge clock);
                cycles++;
            end
            checks++;
            assert (trace[event_base + 3 * event_index] == 0) else begin
                errors++;
                $display("the trace still holds events that never happened");
            end
            $display("test idle after halt: %0d cycles watched", cycles);

            $display("checks %0d, errors %0d", checks, errors);
            if (errors == 0) begin
                $display("Regression passed");
            end else begin
                $display("Regression failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- bench/shader_trace.txt
// @00 program words, @40 initial data RAM words from byte address 0
// @50 events as kind, address, data: 1 data RAM write, 2 SDRAM write, 3 halt, 0 end
@00
00002083 00402103 12308193 40208233 40415293 00112333 001133b3 abcde437
00001497 0041c533 008365b3 0014f633 00409693 00615733 04502023 04702223
04a02423 04b02623 04c02823 04d02a23 04e02c23 00108463 01078793 00109463
00178793 00114463 01078793 00115463 00178793 0020e463 01078793 0020f463
00178793 00208463 00178793 00209463 01078793 0020c463 00178793 0020d463
01078793 00116463 00178793 00117463 01078793 0080086f 10078793 0c5008e7
10078793 04f02e23 07002023 07102223 80000937 10392023 10492223 00100073
@40
12345678 fffffff0
@50
// srai, sltu, xor of addi and sub, or of slt and lui, and with auipc
00000001 00000040 ffffffff
00000001 00000044 00000000
00000001 00000048 00000113
00000001 0000004c abcde001
00000001 00000050 00001020
// slli, srl, branch counter, jal and jalr links
00000001 00000054 23456780
00000001 00000058 7ffffff8
00000001 0000005c 00000006
00000001 00000060 000000b8
00000001 00000064 000000c0
// SDRAM stores of the addi and sub results
00000002 00000100 1234579b
00000002 00000104 12345688
00000003 00000000 00000000
00000000 00000000 00000000

//--- compile.f
+incdir+include
logic/shader_pkg.sv
logic/decode_if.sv
logic/inst_decoder.sv
logic/register_bank.sv
logic/alu.sv
logic/core_sequencer.sv
logic/shader_core.sv
bench/memory_model.sv
bench/shader_core_tb.sv

//--- include/shader_config.svh
`ifndef SHADER_CONFIG_SVH
`define SHADER_CONFIG_SVH

// data and instruction word width
`define SHADER_WORD_WIDTH 32

// instruction RAM and data RAM address width
`define SHADER_ADDRESS_WIDTH 16

// SDRAM write port address width
`define SHADER_SDRAM_ADDRESS_WIDTH 24

// register number width
`define SHADER_REG_ADDRESS_WIDTH 5

// byte distance between instructions
`define SHADER_INST_STEP 4

// system immediate that stops the core
`define SHADER_HALT_CODE 1

`endif

//--- logic/alu.sv
`default_nettype none

`include "shader_config.svh"

module alu (
    decode_if.datapath dec,
    input logic [`SHADER_WORD_WIDTH-1:0] pc,
    input logic [`SHADER_WORD_WIDTH-1:0] rs1_value,
    input logic [`SHADER_WORD_WIDTH-1:0] rs2_value,
    output logic [`SHADER_WORD_WIDTH-1:0] alu_result,
    output logic branch_taken
);
    import shader_pkg::*;

    logic [`SHADER_WORD_WIDTH-1:0] operand1;
    logic [`SHADER_WORD_WIDTH-1:0] operand2_raw;
    logic [`SHADER_WORD_WIDTH-1:0] operand2;
    logic [4:0] shamt;
    logic is_shift;
    logic condition;

    always_comb begin
        case (dec.op_class)
            op_auipc, op_jal, op_branch: operand1 = pc;
            op_lui: operand1 = '0;
            default: operand1 = rs1_value;
        endcase
    end

    assign operand2_raw = (dec.op_class == op_alu_reg) ? rs2_value : dec.imm;
    assign is_shift = (dec.alu_op == alu_sll) || (dec.alu_op == alu_srl)
        || (dec.alu_op == alu_sra);
    assign shamt = operand2_raw[4:0];
    assign operand2 = is_shift ? {{(`SHADER_WORD_WIDTH - 5){1'b0}}, shamt} : operand2_raw;

    always_comb begin
        case (dec.alu_op)
            alu_add: alu_result = operand1 + operand2;
            alu_sub: alu_result = operand1 - operand2;
            alu_sll: alu_result = operand1 << operand2;
            alu_srl: alu_result = operand1 >> operand2;
            alu_sra: alu_result = $unsigned($signed(operand1) >>> operand2);
            alu_xor: alu_result = operand1 ^ operand2;
            alu_and: alu_result = operand1 & operand2;
            alu_or: alu_result = operand1 | operand2;
            alu_slt: alu_result = {{(`SHADER_WORD_WIDTH - 1){1'b0}},
                $signed(operand1) < $signed(operand2)};
            alu_sltu: alu_result = {{(`SHADER_WORD_WIDTH - 1){1'b0}}, operand1 < operand2};
            default: alu_result = '0;
        endcase
    end

    // branch compare always works on the two registers while the alu adds pc and imm
    always_comb begin
        case (dec.funct3)
            3'd0: condition = (rs1_value == rs2_value);
            3'd1: condition = (rs1_value != rs2_value);
            3'd4: condition = $signed(rs1_value) < $signed(rs2_value);
            3'd5: condition = $signed(rs1_value) >= $signed(rs2_value);
            3'd6: condition = rs1_value < rs2_value;
            3'd7: condition = rs1_value >= rs2_value;
            default: condition = 1'b0;
        endcase
    end

    assign branch_taken = (dec.op_class == op_branch) && condition;

endmodule

`default_nettype wire

//--- logic/core_sequencer.sv
`default_nettype none

`include "shader_config.svh"

module core_sequencer (
    input logic clock,
    input logic reset_n,
    input logic run,
    decode_if.control dec,
    input logic [`SHADER_WORD_WIDTH-1:0] rs2_value,
    input logic [`SHADER_WORD_WIDTH-1:0] alu_result,
    input logic branch_taken,
    input logic [`SHADER_WORD_WIDTH-1:0] inst_ram_read_result,
    input logic [`SHADER_WORD_WIDTH-1:0] data_ram_read_result,
    output shader_pkg::inst_word_t inst_word,
    output logic [`SHADER_WORD_WIDTH-1:0] pc,
    output logic rd_write,
    output logic [`SHADER_REG_ADDRESS_WIDTH-1:0] rd_address,
    output logic [`SHADER_WORD_WIDTH-1:0] rd_value,
    output logic halted,
    output logic [`SHADER_ADDRESS_WIDTH-1:0] inst_ram_address,
    output logic [`SHADER_ADDRESS_WIDTH-1:0] data_ram_address,
    output logic [`SHADER_WORD_WIDTH-1:0] data_ram_write_data,
    output logic data_ram_write,
    output logic [`SHADER_SDRAM_ADDRESS_WIDTH-1:0] sdram_address,
    output logic [`SHADER_WORD_WIDTH-1:0] sdram_writedata,
    output logic sdram_write,
    input logic sdram_waitrequest
);
    import shader_pkg::*;

    typedef enum logic [3:0] {
        st_init, st_fetch, st_fetch2, st_decode, st_execute, st_load, st_load2,
        st_store, st_store_stall, st_retire, st_halted
    } state_t;

    state_t state;
    logic writes_rd;
    logic is_jump;
    logic [`SHADER_WORD_WIDTH-1:0] pc_next_seq;

    assign writes_rd = dec.op_class inside {op_alu_imm, op_alu_reg, op_lui, op_auipc,
        op_jal, op_jalr, op_load};
    assign is_jump = (dec.op_class == op_jal) || (dec.op_class == op_jalr);
    assign pc_next_seq = pc + `SHADER_WORD_WIDTH'(`SHADER_INST_STEP);

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state <= st_init;
            pc <= '0;
            rd_write <= 1'b0;
            halted <= 1'b0;
            data_ram_write <= 1'b0;
            sdram_write <= 1'b0;
        end else begin
            // the strobe clears on the next edge even with run low
            data_ram_write <= 1'b0;
            if (run) begin
                case (state)
                    st_init: begin
                        pc <= '0;
                        state <= st_fetch;
                    end
                    st_fetch: begin
                        // the writeback from retire lands at the end of this cycle
                        rd_write <= 1'b0;
                        inst_ram_address <= pc[`SHADER_ADDRESS_WIDTH-1:0];
                        state <= st_fetch2;
                    end
                    st_fetch2: state <= st_decode;
                    st_decode: begin
                        inst_word <= inst_ram_read_result;
                        state <= st_execute;
                    end
                    st_execute: begin
                        halted <= dec.is_halt;
                        rd_address <= dec.rd;
                        if (dec.is_halt) begin
                            state <= st_halted;
                        end else if (dec.op_class == op_load) begin
                            state <= st_load;
                        end else if (dec.op_class == op_store) begin
                            state <= st_store;
                        end else begin
                            state <= st_retire;
                        end
                    end
                    st_load: begin
                        data_ram_address <= alu_result[`SHADER_ADDRESS_WIDTH-1:0];
                        state <= st_load2;
                    end
                    st_load2: state <= st_retire;
                    st_store: begin
                        // bit 31 of the address selects the SDRAM port
                        if (alu_result[`SHADER_WORD_WIDTH-1]) begin
                            sdram_address <= alu_result[`SHADER_SDRAM_ADDRESS_WIDTH-1:0];
                            sdram_writedata <= rs2_value;
                            sdram_write <= 1'b1;
                            state <= st_store_stall;
                        end else begin
                            data_ram_address <= alu_result[`SHADER_ADDRESS_WIDTH-1:0];
                            data_ram_write_data <= rs2_value;
                            data_ram_write <= 1'b1;
                            state <= st_retire;
                        end
                    end
                    st_store_stall: begin
                        if (!sdram_waitrequest) begin
                            sdram_write <= 1'b0;
                            state <= st_retire;
                        end
                    end
                    st_retire: begin
                        rd_write <= writes_rd && (rd_address != '0);
                        if (is_jump) begin
                            rd_value <= pc_next_seq;
                        end else if (dec.op_class == op_load) begin
                            rd_value <= data_ram_read_result;
                        end else begin
                            rd_value <= alu_result;
                        end
                        if (is_jump) begin
                            pc <= {alu_result[`SHADER_WORD_WIDTH-1:1], 1'b0};
                        end else if (branch_taken) begin
                            pc <= alu_result;
                        end else begin
                            pc <= pc_next_seq;
                        end
                        state <= st_fetch;
                    end
                    st_halted: state <= st_halted;
                    default: state <= st_init;
                endcase
            end
        end
    end

    data_ram_strobe: assert property (@(posedge clock) disable iff (!reset_n)
        data_ram_write |=> !data_ram_write)
        else $error("data_ram_write held for two cycles");

    // the write is only accepted at an edge with waitrequest low
    sdram_hold: assert property (@(posedge clock) disable iff (!reset_n)
        $fell(sdram_write) |-> $past(!sdram_waitrequest))
        else $error("sdram_write dropped while waitrequest was high");

endmodule

`default_nettype wire

//--- logic/decode_if.sv
`default_nettype none

`include "shader_config.svh"

interface decode_if;
    import shader_pkg::*;

    op_class_t op_class;
    alu_op_t alu_op;
    logic [`SHADER_REG_ADDRESS_WIDTH-1:0] rs1;
    logic [`SHADER_REG_ADDRESS_WIDTH-1:0] rs2;
    logic [`SHADER_REG_ADDRESS_WIDTH-1:0] rd;
    logic [2:0] funct3;
    // already sign-extended, or the zero-extended shamt for shift immediates
    logic [`SHADER_WORD_WIDTH-1:0] imm;
    logic is_halt;

    modport decoder (output op_class, alu_op, rs1, rs2, rd, funct3, imm, is_halt);
    modport control (input op_class, alu_op, rs1, rs2, rd, funct3, imm, is_halt);
    modport datapath (input op_class, alu_op, funct3, imm);
    modport regs (input rs1, rs2);

endinterface

`default_nettype wire

//--- logic/inst_decoder.sv
`default_nettype none

`include "shader_config.svh"

module inst_decoder (
    input shader_pkg::inst_word_t inst_word,
    decode_if.decoder dec
);
    import shader_pkg::*;

    localparam logic [6:0] opc_alu_imm = 7'b0010011;
    localparam logic [6:0] opc_alu_reg = 7'b0110011;
    localparam logic [6:0] opc_lui = 7'b0110111;
    localparam logic [6:0] opc_auipc = 7'b0010111;
    localparam logic [6:0] opc_jal = 7'b1101111;
    localparam logic [6:0] opc_jalr = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load = 7'b0000011;
    localparam logic [6:0] opc_store = 7'b0100011;
    localparam logic [6:0] opc_system = 7'b1110011;

    localparam int sign_fill = `SHADER_WORD_WIDTH - 12;

    logic [2:0] funct3;
    logic alt_bit;
    logic is_shift;

    // alt selects sub for add and sra for srl
    function automatic alu_op_t funct3_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0: funct3_op = alt ? alu_sub : alu_add;
            3'd1: funct3_op = alu_sll;
            3'd2: funct3_op = alu_slt;
            3'd3: funct3_op = alu_sltu;
            3'd4: funct3_op = alu_xor;
            3'd5: funct3_op = alt ? alu_sra : alu_srl;
            3'd6: funct3_op = alu_or;
            default: funct3_op = alu_and;
        endcase
    endfunction

    assign funct3 = inst_word.r_fmt.funct3;
    // instruction bit 30 sits inside funct7 for R and inside the immediate for I
    assign alt_bit = inst_word.r_fmt.funct7[5];
    assign is_shift = (funct3 == 3'd1) || (funct3 == 3'd5);

    // register fields sit at the same place in every format
    assign dec.rs1 = inst_word.r_fmt.rs1;
    assign dec.rs2 = inst_word.r_fmt.rs2;
    assign dec.rd = inst_word.r_fmt.rd;
    assign dec.funct3 = funct3;
    assign dec.is_halt = (dec.op_class == op_system)
        && (inst_word.i_fmt.imm == 12'(`SHADER_HALT_CODE));

    always_comb begin
        dec.op_class = op_illegal;
        dec.alu_op = alu_add;
        dec.imm = {{sign_fill{inst_word.i_fmt.imm[11]}}, inst_word.i_fmt.imm};
        case (inst_word.r_fmt.opcode)
            opc_alu_imm: begin
                dec.op_class = op_alu_imm;
                // addi has no subtract form
                dec.alu_op = funct3_op(funct3, alt_bit && (funct3 == 3'd5));
                if (is_shift) begin
                    // shamt lives in the rs2 field
                    dec.imm = {{(`SHADER_WORD_WIDTH - 5){1'b0}}, inst_word.r_fmt.rs2};
                end
            end
            opc_alu_reg: begin
                dec.op_class = op_alu_reg;
                dec.alu_op = funct3_op(funct3, alt_bit);
            end
            opc_lui: begin
                dec.op_class = op_lui;
                dec.imm = {inst_word.u_fmt.imm, 12'b0};
            end
            opc_auipc: begin
                dec.op_class = op_auipc;
                dec.imm = {inst_word.u_fmt.imm, 12'b0};
            end
            opc_jal: begin
                dec.op_class = op_jal;
                dec.imm = {{(sign_fill - 8){inst_word.j_fmt.imm_20}},
                    inst_word.j_fmt.imm_19_12, inst_word.j_fmt.imm_11,
                    inst_word.j_fmt.imm_10_1, 1'b0};
            end
            opc_jalr: dec.op_class = op_jalr;
            opc_branch: begin
                dec.op_class = op_branch;
                dec.imm = {{sign_fill{inst_word.b_fmt.imm_12}},
                    inst_word.b_fmt.imm_11, inst_word.b_fmt.imm_10_5,
                    inst_word.b_fmt.imm_4_1, 1'b0};
            end
            opc_load: dec.op_class = op_load;
            opc_store: begin
                dec.op_class = op_store;
                dec.imm = {{sign_fill{inst_word.s_fmt.imm_hi[6]}},
                    inst_word.s_fmt.imm_hi, inst_word.s_fmt.imm_lo};
            end
            opc_system: begin
                dec.op_class = op_system;
                dec.alu_op = alu_none;
            end
            default: dec.alu_op = alu_none;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/register_bank.sv
`default_nettype none

`include "shader_config.svh"

module register_bank (
    input logic clock,
    decode_if.regs dec,
    input logic rd_write,
    input logic [`SHADER_REG_ADDRESS_WIDTH-1:0] rd_address,
    input logic [`SHADER_WORD_WIDTH-1:0] rd_value,
    output logic [`SHADER_WORD_WIDTH-1:0] rs1_value,
    output logic [`SHADER_WORD_WIDTH-1:0] rs2_value
);

    localparam int reg_count = 1 << `SHADER_REG_ADDRESS_WIDTH;

    // x0 has no storage
    logic [`SHADER_WORD_WIDTH-1:0] regs [1:reg_count-1];

    always_ff @(posedge clock) begin
        if (rd_write && (rd_address != '0)) begin
            regs[rd_address] <= rd_value;
        end
    end

    assign rs1_value = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
    assign rs2_value = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

    // the sequencer drops writes to x0 before they get here
    no_x0_write: assert property (@(posedge clock) rd_write |-> (rd_address != '0))
        else $error("register write to x0");

endmodule

`default_nettype wire

//--- logic/shader_core.sv
`default_nettype none

`include "shader_config.svh"

module shader_core (
    input logic clock,
    input logic reset_n,
    input logic run,
    output logic halted,
    output logic [`SHADER_ADDRESS_WIDTH-1:0] inst_ram_address,
    input logic [`SHADER_WORD_WIDTH-1:0] inst_ram_read_result,
    output logic [`SHADER_ADDRESS_WIDTH-1:0] data_ram_address,
    output logic [`SHADER_WORD_WIDTH-1:0] data_ram_write_data,
    output logic data_ram_write,
    input logic [`SHADER_WORD_WIDTH-1:0] data_ram_read_result,
    output logic [`SHADER_SDRAM_ADDRESS_WIDTH-1:0] sdram_address,
    output logic [`SHADER_WORD_WIDTH-1:0] sdram_writedata,
    output logic sdram_write,
    input logic sdram_waitrequest
);
    import shader_pkg::*;

    inst_word_t inst_word;
    logic [`SHADER_WORD_WIDTH-1:0] pc;
    logic [`SHADER_WORD_WIDTH-1:0] rs1_value;
    logic [`SHADER_WORD_WIDTH-1:0] rs2_value;
    logic [`SHADER_WORD_WIDTH-1:0] alu_result;
    logic branch_taken;
    logic rd_write;
    logic [`SHADER_REG_ADDRESS_WIDTH-1:0] rd_address;
    logic [`SHADER_WORD_WIDTH-1:0] rd_value;

    decode_if dec_if ();

    core_sequencer sequencer_i (
        .clock(clock),
        .reset_n(reset_n),
        .run(run),
        .dec(dec_if.control),
        .rs2_value(rs2_value),
        .alu_result(alu_result),
        .branch_taken(branch_taken),
        .inst_ram_read_result(inst_ram_read_result),
        .data_ram_read_result(data_ram_read_result),
        .inst_word(inst_word),
        .pc(pc),
        .rd_write(rd_write),
        .rd_address(rd_address),
        .rd_value(rd_value),
        .halted(halted),
        .inst_ram_address(inst_ram_address),
        .data_ram_address(data_ram_address),
        .data_ram_write_data(data_ram_write_data),
        .data_ram_write(data_ram_write),
        .sdram_address(sdram_address),
        .sdram_writedata(sdram_writedata),
        .sdram_write(sdram_write),
        .sdram_waitrequest(sdram_waitrequest)
    );

    inst_decoder decoder_i (
        .inst_word(inst_word),
        .dec(dec_if.decoder)
    );

    register_bank regs_i (
        .clock(clock),
        .dec(dec_if.regs),
        .rd_write(rd_write),
        .rd_address(rd_address),
        .rd_value(rd_value),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value)
    );

    alu alu_i (
        .dec(dec_if.datapath),
        .pc(pc),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value),
        .alu_result(alu_result),
        .branch_taken(branch_taken)
    );

endmodule

`default_nettype wire

//--- logic/shader_pkg.sv
`default_nettype none

package shader_pkg;

    // the same instruction word, seen through each RISC-V format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } inst_word_t;

    typedef enum logic [3:0] {
        op_alu_imm, op_alu_reg, op_lui, op_auipc, op_jal, op_jalr,
        op_branch, op_load, op_store, op_system, op_illegal
    } op_class_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_srl, alu_sra, alu_xor,
        alu_and, alu_or, alu_slt, alu_sltu, alu_none
    } alu_op_t;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f compile.f --top-module shader_core_tb -Mdir obj_dir \
    && ./obj_dir/Vshader_core_tb > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Regression failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Regression passed" sim.log || { echo "no result found in sim.log"; exit 1; }
exit 0
